/* logic/loudness_settings.svh */
`ifndef LOUDNESS_SETTINGS_SVH
`define LOUDNESS_SETTINGS_SVH

// Audio sample path
`define LD_SAMPLE_W    16  // Signed input sample width
`define LD_TAPS        4   // Moving-average length
`define LD_DECIM       4   // Keep one filtered value in four

// Frame and transform geometry
`define LD_FFT_POINTS  8   // Samples per frame
`define LD_FFT_LOG2    3   // Radix-2 stages, also index width

// Result
`define LD_POWER_W     32  // Loudness word width

`endif

/* logic/loudness_pkg.sv */
`include "loudness_settings.svh"

package loudness_pkg;

    typedef logic signed [`LD_SAMPLE_W-1:0] sample_t;  // Raw and filtered audio
    typedef logic signed [15:0]             bin_t;     // One FFT component, re or im
    typedef logic        [`LD_POWER_W-1:0]  power_t;   // Summed bin power

    // Controller sequencing
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a full bank
        FFT,    // Engine loading and running
        ACCUM   // Power sum in progress
    } ctl_state_t;

endpackage

/* logic/anti_alias_decimator.sv */
`timescale 1ns/1ps
`include "loudness_settings.svh"

module anti_alias_decimator (
    input  logic                  audio_clk,
    input  logic                  rst_n,
    input  loudness_pkg::sample_t sample_in,
    input  logic                  sample_valid,
    output loudness_pkg::sample_t dec_sample,
    output logic                  dec_valid
);

    localparam int PHASE_W = $clog2(`LD_DECIM);
    localparam int SHIFT   = $clog2(`LD_TAPS);     // Divide by tap count
    localparam int SUM_W   = `LD_SAMPLE_W + SHIFT; // Headroom for the tap sum

    loudness_pkg::sample_t   hist [`LD_TAPS-1];   // Older inputs, newest at 0
    logic [PHASE_W-1:0]      phase;               // Decimation phase
    logic signed [SUM_W-1:0] tap_sum;             // Current input plus history
    logic                    keep;                // This input survives decimation

    always_comb begin
        tap_sum = SUM_W'(sample_in);                 // Sign extended
        for (int i = 0; i < `LD_TAPS-1; i++) begin
            tap_sum = tap_sum + SUM_W'(hist[i]);
        end
    end

    assign keep = sample_valid && (phase == PHASE_W'(`LD_DECIM-1));

    always_ff @(posedge audio_clk) begin
        if (!rst_n) begin
            phase     <= '0;
            dec_valid <= 1'b0;
            for (int i = 0; i < `LD_TAPS-1; i++) begin
                hist[i] <= '0;                       // Filter starts from silence
            end
        end else begin
            dec_valid <= keep;                       // One cycle after the input
            if (sample_valid) begin
                hist[0] <= sample_in;
                for (int i = 1; i < `LD_TAPS-1; i++) begin
                    hist[i] <= hist[i-1];            // Shift the delay line
                end
                if (phase == PHASE_W'(`LD_DECIM-1)) begin
                    phase <= '0;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (keep) begin
            dec_sample <= tap_sum[SUM_W-1:SHIFT];    // Mean of the taps
        end
    end

endmodule

/* logic/frame_buffer.sv */
`timescale 1ns/1ps
`include "loudness_settings.svh"

module frame_buffer (
    input  logic                    audio_clk,
    input  logic                    rst_n,
    input  loudness_pkg::sample_t   dec_sample,
    input  logic                    dec_valid,
    input  logic                    bank_swap,
    input  logic [`LD_FFT_LOG2-1:0] rd_index,
    output loudness_pkg::sample_t   rd_sample,
    output logic                    frame_full
);

    localparam int IDX_W = `LD_FFT_LOG2;

    loudness_pkg::sample_t bank_mem [2][`LD_FFT_POINTS]; // Ping-pong frame store
    logic                  wr_bank;                      // Bank being filled
    logic [IDX_W-1:0]      wr_cnt;                       // Samples in current bank

    // Mirror the index bits so the FFT can run in place on natural order
    function automatic logic [IDX_W-1:0] bit_rev(input logic [IDX_W-1:0] idx);
        logic [IDX_W-1:0] rev;
        for (int b = 0; b < IDX_W; b++) begin
            rev[b] = idx[IDX_W-1-b];
        end
        return rev;
    endfunction

    always_ff @(posedge audio_clk) begin
        if (!rst_n) begin
            wr_bank    <= 1'b0;
            wr_cnt     <= '0;
            frame_full <= 1'b0;
        end else begin
            frame_full <= dec_valid && (wr_cnt == IDX_W'(`LD_FFT_POINTS-1)); // 8th write
            if (dec_valid) begin
                wr_cnt <= wr_cnt + 1'b1;            // Wraps to 0 after a frame
            end
            if (bank_swap) begin
                wr_bank <= ~wr_bank;                // Read side follows as the other bank
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (dec_valid) begin
            bank_mem[wr_bank][bit_rev(wr_cnt)] <= dec_sample;
        end
    end

    assign rd_sample = bank_mem[~wr_bank][rd_index]; // Async read of finished bank

endmodule

/* logic/fft_butterfly_engine.sv */
`timescale 1ns/1ps
`include "loudness_settings.svh"

module fft_butterfly_engine (
    input  logic                    audio_clk,
    input  logic                    rst_n,
    input  logic                    fft_start,
    output logic [`LD_FFT_LOG2-1:0] rd_index,
    input  loudness_pkg::sample_t   rd_sample,
    input  logic [`LD_FFT_LOG2-1:0] bin_index,
    output loudness_pkg::bin_t      bin_re,
    output loudness_pkg::bin_t      bin_im,
    output logic                    fft_done
);

    localparam int IDX_W  = `LD_FFT_LOG2;
    localparam int PAIR_W = `LD_FFT_LOG2 - 1;       // Four butterflies per stage
    localparam int STG_W  = $clog2(`LD_FFT_LOG2);

    loudness_pkg::bin_t  x_re [`LD_FFT_POINTS];     // In-place working set
    loudness_pkg::bin_t  x_im [`LD_FFT_POINTS];
    logic                load_active;               // Copying the frame in
    logic                bfly_active;               // Butterflies running
    logic [IDX_W-1:0]    load_cnt;
    logic [STG_W-1:0]    stage;
    logic [PAIR_W-1:0]   pair;
    logic [IDX_W-1:0]    span_mask;                 // Span minus one
    logic [IDX_W-1:0]    top_idx;
    logic [IDX_W-1:0]    bot_idx;
    logic [PAIR_W-1:0]   tw_idx;                    // Exponent of W8
    loudness_pkg::bin_t  w_re;
    loudness_pkg::bin_t  w_im;
    logic signed [32:0]  t_re_full;                 // Full precision twiddle product
    logic signed [32:0]  t_im_full;
    logic signed [17:0]  t_re;                      // Back in Q15 scale
    logic signed [17:0]  t_im;
    logic signed [18:0]  sum_re;
    logic signed [18:0]  sum_im;
    logic signed [18:0]  dif_re;
    logic signed [18:0]  dif_im;

    // Butterfly addressing for decimation in time with bit-reversed input
    always_comb begin
        span_mask = (IDX_W'(1) << stage) - IDX_W'(1);
        top_idx   = ((IDX_W'(pair) & ~span_mask) << 1) | (IDX_W'(pair) & span_mask);
        bot_idx   = top_idx | (IDX_W'(1) << stage);
        tw_idx    = PAIR_W'((IDX_W'(pair) & span_mask) << (IDX_W - 1 - stage));
    end

    // Twiddle ROM, W8^k = cos - j sin in Q1.15
    always_comb begin
        case (tw_idx)
            2'd0:    begin w_re = 16'sd32767;  w_im = 16'sd0;      end
            2'd1:    begin w_re = 16'sd23170;  w_im = -16'sd23170; end
            2'd2:    begin w_re = 16'sd0;      w_im = -16'sd32767; end
            default: begin w_re = -16'sd23170; w_im = -16'sd23170; end
        endcase
    end

    always_comb begin
        t_re_full = w_re * x_re[bot_idx] - w_im * x_im[bot_idx];
        t_im_full = w_re * x_im[bot_idx] + w_im * x_re[bot_idx];
        if (tw_idx == '0) begin
            t_re = 18'(x_re[bot_idx]);              // Unity twiddle taken exactly
            t_im = 18'(x_im[bot_idx]);
        end else begin
            t_re = t_re_full[32:15];                // Drop Q15 fraction
            t_im = t_im_full[32:15];
        end
        sum_re = x_re[top_idx] + t_re;
        sum_im = x_im[top_idx] + t_im;
        dif_re = x_re[top_idx] - t_re;
        dif_im = x_im[top_idx] - t_im;
    end

    always_ff @(posedge audio_clk) begin
        if (!rst_n) begin
            load_active <= 1'b0;
            bfly_active <= 1'b0;
            load_cnt    <= '0;
            stage       <= '0;
            pair        <= '0;
            fft_done    <= 1'b0;
        end else begin
            fft_done <= 1'b0;
            if (fft_start) begin
                load_active <= 1'b1;                // Restart even mid-run
                bfly_active <= 1'b0;
                load_cnt    <= '0;
            end else if (load_active) begin
                load_cnt <= load_cnt + 1'b1;
                if (load_cnt == IDX_W'(`LD_FFT_POINTS-1)) begin
                    load_active <= 1'b0;
                    bfly_active <= 1'b1;
                    stage       <= '0;
                    pair        <= '0;
                end
            end else if (bfly_active) begin
                pair <= pair + 1'b1;
                if (pair == '1) begin
                    if (stage == STG_W'(`LD_FFT_LOG2-1)) begin
                        bfly_active <= 1'b0;
                        fft_done    <= 1'b1;        // Last stage written
                    end else begin
                        stage <= stage + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (load_active && !fft_start) begin
            x_re[load_cnt] <= rd_sample;            // Real audio only
            x_im[load_cnt] <= '0;
        end else if (bfly_active && !fft_start) begin
            x_re[top_idx] <= sum_re[16:1];          // Halve every stage
            x_im[top_idx] <= sum_im[16:1];
            x_re[bot_idx] <= dif_re[16:1];
            x_im[bot_idx] <= dif_im[16:1];
        end
    end

    assign rd_index = load_cnt;
    assign bin_re   = x_re[bin_index];              // Held until next start
    assign bin_im   = x_im[bin_index];

endmodule

/* logic/power_accumulator.sv */
`timescale 1ns/1ps
`include "loudness_settings.svh"

module power_accumulator (
    input  logic                    audio_clk,
    input  logic                    rst_n,
    input  logic                    acc_start,
    output logic [`LD_FFT_LOG2-1:0] bin_index,
    input  loudness_pkg::bin_t      bin_re,
    input  loudness_pkg::bin_t      bin_im,
    output loudness_pkg::power_t    loudness,
    output logic                    acc_done
);

    localparam int IDX_W = `LD_FFT_LOG2;

    logic                          active;      // Walking the bins
    logic                          last;        // Final bin added
    logic [IDX_W-1:0]              idx;
    loudness_pkg::power_t          acc_sum;     // Running total
    logic signed [`LD_POWER_W-1:0] sq_re;
    logic signed [`LD_POWER_W-1:0] sq_im;
    loudness_pkg::power_t          bin_pwr;     // |X[k]|^2

    always_comb begin
        sq_re   = bin_re * bin_re;              // Never negative
        sq_im   = bin_im * bin_im;
        bin_pwr = $unsigned(sq_re) + $unsigned(sq_im);
    end

    always_ff @(posedge audio_clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            last     <= 1'b0;
            idx      <= '0;
            acc_done <= 1'b0;
        end else begin
            last     <= 1'b0;
            acc_done <= last;                   // One cycle after the final add
            if (acc_start) begin
                active <= 1'b1;
                idx    <= '0;
            end else if (active) begin
                idx <= idx + 1'b1;
                if (idx == IDX_W'(`LD_FFT_POINTS-1)) begin
                    active <= 1'b0;
                    last   <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge audio_clk) begin
        if (acc_start) begin
            acc_sum <= '0;
        end else if (active) begin
            acc_sum <= acc_sum + bin_pwr;
        end
        if (last) begin
            loudness <= acc_sum;                // Frame total
        end
    end

    assign bin_index = idx;

endmodule

/* logic/loudness_control.sv */
`timescale 1ns/1ps

module loudness_control (
    input  logic audio_clk,
    input  logic rst_n,
    input  logic frame_full,
    input  logic fft_done,
    input  logic acc_done,
    output logic bank_swap,
    output logic fft_start,
    output logic acc_start
);

    loudness_pkg::ctl_state_t state;
    logic                     pending;   // Frame finished while busy
    logic                     serve;     // Launch a transform now

    assign serve     = (state == loudness_pkg::IDLE) && (frame_full || pending);
    assign bank_swap = serve;            // Swap and start together
    assign fft_start = serve;

    always_ff @(posedge audio_clk) begin
        if (!rst_n) begin
            state     <= loudness_pkg::IDLE;
            pending   <= 1'b0;
            acc_start <= 1'b0;
        end else begin
            acc_start <= 1'b0;
            if (serve) begin
                pending <= 1'b0;
            end else if (frame_full) begin
                pending <= 1'b1;         // Served on return to IDLE
            end
            case (state)
                loudness_pkg::IDLE: begin
                    if (serve) begin
                        state <= loudness_pkg::FFT;
                    end
                end
                loudness_pkg::FFT: begin
                    if (fft_done) begin
                        acc_start <= 1'b1;   // Bins are stable now
                        state     <= loudness_pkg::ACCUM;
                    end
                end
                loudness_pkg::ACCUM: begin
                    if (acc_done) begin
                        state <= loudness_pkg::IDLE;
                    end
                end
                default: state <= loudness_pkg::IDLE;
            endcase
        end
    end

endmodule

/* logic/fft_loudness_detect.sv */
`timescale 1ns/1ps
`include "loudness_settings.svh"

module fft_loudness_detect (
    input  logic                 audio_clk,
    input  logic                 rst_n,
    input  loudness_pkg::sample_t sample_in,
    input  logic                 sample_valid,
    output loudness_pkg::power_t loudness,
    output logic                 loudness_valid
);

    loudness_pkg::sample_t   dec_sample;   // Filtered, decimated audio
    logic                    dec_valid;
    logic                    frame_full;
    logic                    bank_swap;
    logic                    fft_start;
    logic                    fft_done;
    logic                    acc_start;
    logic [`LD_FFT_LOG2-1:0] rd_index;     // Engine reads finished bank
    loudness_pkg::sample_t   rd_sample;
    logic [`LD_FFT_LOG2-1:0] bin_index;    // Accumulator reads bins
    loudness_pkg::bin_t      bin_re;
    loudness_pkg::bin_t      bin_im;

    anti_alias_decimator u_decimator (
        .audio_clk    (audio_clk),
        .rst_n        (rst_n),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .dec_sample   (dec_sample),
        .dec_valid    (dec_valid)
    );

    frame_buffer u_frame_buffer (
        .audio_clk  (audio_clk),
        .rst_n      (rst_n),
        .dec_sample (dec_sample),
        .dec_valid  (dec_valid),
        .bank_swap  (bank_swap),
        .rd_index   (rd_index),
        .rd_sample  (rd_sample),
        .frame_full (frame_full)
    );

    fft_butterfly_engine u_fft (
        .audio_clk (audio_clk),
        .rst_n     (rst_n),
        .fft_start (fft_start),
        .rd_index  (rd_index),
        .rd_sample (rd_sample),
        .bin_index (bin_index),
        .bin_re    (bin_re),
        .bin_im    (bin_im),
        .fft_done  (fft_done)
    );

    power_accumulator u_power_acc (
        .audio_clk (audio_clk),
        .rst_n     (rst_n),
        .acc_start (acc_start),
        .bin_index (bin_index),
        .bin_re    (bin_re),
        .bin_im    (bin_im),
        .loudness  (loudness),
        .acc_done  (loudness_valid)   // Done strobe is the output valid
    );

    loudness_control u_control (
        .audio_clk  (audio_clk),
        .rst_n      (rst_n),
        .frame_full (frame_full),
        .fft_done   (fft_done),
        .acc_done   (loudness_valid),
        .bank_swap  (bank_swap),
        .fft_start  (fft_start),
        .acc_start  (acc_start)
    );

endmodule

/* verification/loudness_checker.sv */
`timescale 1ns/1ps

module loudness_checker (
    input logic                     audio_clk,
    input logic                     rst_n,
    input logic                     loudness_valid,
    input logic                     fft_done,
    input logic                     fft_start,
    input logic                     acc_start,
    input loudness_pkg::ctl_state_t state
);

    localparam int MAX_BUSY = 40;   // Longest stay outside IDLE

    logic [7:0] busy_len;           // Cycles since leaving IDLE
    logic       in_flight;          // Frame between fft_start and loudness_valid

    always_ff @(posedge audio_clk) begin
        if (!rst_n) begin
            busy_len <= '0;
        end else if (state == loudness_pkg::IDLE) begin
            busy_len <= '0;
        end else if (busy_len != '1) begin
            busy_len <= busy_len + 1'b1;   // Saturates
        end
    end

    always_ff @(posedge audio_clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
        end else if (fft_start) begin
            in_flight <= 1'b1;
        end else if (loudness_valid) begin
            in_flight <= 1'b0;             // Result out, datapath free again
        end
    end

    assert property (@(posedge audio_clk) disable iff (!rst_n)
                     loudness_valid |=> !loudness_valid)
        else $error("loudness_valid held for more than one cycle");

    assert property (@(posedge audio_clk) disable iff (!rst_n) fft_start |-> !in_flight)
        else $error("fft_start raised while the previous frame is still in flight");

    assert property (@(posedge audio_clk) disable iff (!rst_n) fft_done |=> acc_start)
        else $error("acc_start missing after fft_done");

    assert property (@(posedge audio_clk) disable iff (!rst_n) busy_len <= 8'(MAX_BUSY))
        else $error("Controller stuck outside IDLE");

endmodule

/* verification/fft_loudness_detect_tb.sv */
`timescale 1ns/1ps
`include "loudness_settings.svh"

module fft_loudness_detect_tb;

    localparam int N_ENTRIES      = 9;
    localparam int FRAMES_PER_ENT = 3;                            // First two may mix levels
    localparam int FRAME_INPUTS   = `LD_FFT_POINTS * `LD_DECIM;   // Raw inputs per frame
    localparam int ENTRY_INPUTS   = FRAMES_PER_ENT * FRAME_INPUTS;
    localparam int N_RESULTS      = N_ENTRIES * FRAMES_PER_ENT;
    localparam int MIN_GAP        = 5;                            // No back-pressure in DUT
    localparam int MAX_GAP        = 8;
    localparam int TIMEOUT_CYCLES = N_ENTRIES * ENTRY_INPUTS * MAX_GAP + 600;
    localparam logic [31:0] SEED  = 32'h5b60_c21a;

    localparam int KIND_CONST = 0;   // Steady level
    localparam int KIND_ALT2  = 1;   // +a -a
    localparam int KIND_ALT4  = 2;   // +a +a -a -a

    // Pattern, amplitude and expected loudness per entry
    localparam int KIND_TBL [N_ENTRIES] = '{
        KIND_CONST, KIND_CONST, KIND_CONST, KIND_CONST, KIND_CONST,
        KIND_CONST, KIND_ALT2, KIND_ALT4, KIND_CONST
    };
    localparam int AMP_TBL [N_ENTRIES] = '{
        0, 100, 1000, 16000, -1000, -16000, 5000, 12000, 100
    };
    localparam logic [31:0] EXP_TBL [N_ENTRIES] = '{
        32'd0,            // 0 squared
        32'd10000,        // 100 squared
        32'd1000000,
        32'd256000000,    // Full bin 0 at 16000
        32'd1000000,      // Sign drops out of the square
        32'd256000000,
        32'd0,            // Filter nulls period 2
        32'd0,            // Filter nulls period 4
        32'd10000
    };

    logic                  audio_clk;
    logic                  rst_n;
    loudness_pkg::sample_t sample_in;
    logic                  sample_valid;
    loudness_pkg::power_t  loudness;
    logic                  loudness_valid;

    int   cycle_cnt      = 0;
    int   inputs_applied = 0;   // Inputs seen by the DUT
    int   pulse_cnt      = 0;   // loudness_valid pulses so far
    logic valid_q        = 1'b0;

    initial audio_clk = 1'b0;
    always #4 audio_clk = ~audio_clk;   // 8 ns period

    fft_loudness_detect DUT (
        .audio_clk      (audio_clk),
        .rst_n          (rst_n),
        .sample_in      (sample_in),
        .sample_valid   (sample_valid),
        .loudness       (loudness),
        .loudness_valid (loudness_valid)
    );

    bind fft_loudness_detect loudness_checker u_checker (
        .audio_clk      (audio_clk),
        .rst_n          (rst_n),
        .loudness_valid (loudness_valid),
        .fft_done       (fft_done),
        .fft_start      (fft_start),
        .acc_start      (acc_start),
        .state          (u_control.state)   // Controller FSM state
    );

    function automatic int pattern_value(input int kind, input int amp, input int n);
        if (kind == KIND_ALT2) begin
            return n[0] ? -amp : amp;
        end else if (kind == KIND_ALT4) begin
            return n[1] ? -amp : amp;
        end
        return amp;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // One-cycle strobe, then idle for the rest of the gap
    task automatic drive_input(input int value, input int gap);
        sample_in    = loudness_pkg::sample_t'(value);
        sample_valid = 1'b1;
        @(posedge audio_clk);
        #1;
        sample_valid   = 1'b0;
        inputs_applied = inputs_applied + 1;
        repeat (gap - 1) begin
            @(posedge audio_clk);
            #1;
        end
    endtask

    always @(posedge audio_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: loudness_valid pulses never arrived within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Only %0d of %0d results were seen", pulse_cnt, N_RESULTS);
            $display("ERRORS FOUND");
            $fatal(1, "Run stopped by timeout");
        end
    end

    // Result monitor, sampled away from the active edge
    always @(negedge audio_clk) begin
        if (rst_n) begin
            if (inputs_applied < FRAME_INPUTS) begin
                check_value(32'(loudness_valid), 32'd0, "loudness_valid before first frame");
            end
            if (loudness_valid) begin
                check_value(32'(valid_q), 32'd0, "loudness_valid longer than one cycle");
                check_value(32'(pulse_cnt < N_RESULTS), 32'd1, "loudness_valid beyond last frame");
                if (pulse_cnt % FRAMES_PER_ENT == FRAMES_PER_ENT - 1) begin
                    check_value(loudness, EXP_TBL[pulse_cnt / FRAMES_PER_ENT], "loudness");
                end
                pulse_cnt = pulse_cnt + 1;
            end
        end
        valid_q = loudness_valid;
    end

    initial begin
        int gap;
        rst_n        = 1'b0;
        sample_in    = '0;
        sample_valid = 1'b0;
        void'($urandom(SEED));
        repeat (8) @(posedge audio_clk);
        #1;
        rst_n = 1'b1;
        for (int e = 0; e < N_ENTRIES; e++) begin
            for (int n = 0; n < ENTRY_INPUTS; n++) begin
                gap = MIN_GAP + int'($urandom % (MAX_GAP - MIN_GAP + 1));
                drive_input(pattern_value(KIND_TBL[e], AMP_TBL[e], n), gap);
            end
        end
        while (pulse_cnt < N_RESULTS) begin
            @(posedge audio_clk);
        end
        repeat (60) @(posedge audio_clk);   // Catch any stray extra pulse
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/loudness_pkg.sv
logic/anti_alias_decimator.sv
logic/frame_buffer.sv
logic/fft_butterfly_engine.sv
logic/power_accumulator.sv
logic/loudness_control.sv
logic/fft_loudness_detect.sv
verification/loudness_checker.sv
verification/fft_loudness_detect_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fft_loudness_detect_tb \
    -f sources.f

sim_out="$(./obj_dir/Vfft_loudness_detect_tb 2>&1 || true)"
echo "$sim_out"

if grep -qx "NO ERRORS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
